//--- design/mipsPkg.sv
package mipsPkg;

	typedef logic [31:0] wordT;
	typedef logic [4:0]  regAddrT;

	typedef enum logic [2:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu
	} aluOpT;

	// encoded like funct[1:0] of the shift instructions
	typedef enum logic [1:0] {
		shSll = 2'b00,
		shSrl = 2'b10,
		shSra = 2'b11
	} shiftOpT;

	typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} accessSizeT;
	typedef enum logic [1:0] {srcRs, srcLink, srcZero} aSrcT;
	typedef enum logic [1:0] {srcRt, srcImm, srcStep} bSrcT;
	typedef enum logic [1:0] {immSign, immZero, immUpper} immKindT;
	typedef enum logic [2:0] {brEq, brNe, brLez, brGtz, brLtz, brGez} branchKindT;

	typedef struct packed {
		aluOpT      aluOp;
		shiftOpT    shiftOp;
		aSrcT       aSrc;
		bSrcT       bSrc;
		branchKindT branchKind;
		logic       isLoad;
		logic       isStore;
		logic       isBranch;
		logic       isJump;
		logic       isLink;
		logic       isShift;
		logic       isRegJump;
		logic       isNop;
		logic       regWriteEnable;
		regAddrT    writeReg;
		accessSizeT accessSize;
		logic       loadUnsigned;
		immKindT    immKind;
	} ctrlT;

	typedef struct packed {
		wordT       addr;
		wordT       wdata;
		logic [3:0] strb;
		logic       write;
	} memReqT;

	typedef struct packed {
		logic    wen;
		regAddrT waddr;
		wordT    wdata;
		wordT    pc;
	} retireT;

	localparam logic [5:0] opSpecial = 6'b000000;
	localparam logic [5:0] opRegimm  = 6'b000001;
	localparam logic [5:0] opJ       = 6'b000010;
	localparam logic [5:0] opJal     = 6'b000011;
	localparam logic [5:0] opBeq     = 6'b000100;
	localparam logic [5:0] opBne     = 6'b000101;
	localparam logic [5:0] opBlez    = 6'b000110;
	localparam logic [5:0] opBgtz    = 6'b000111;
	localparam logic [5:0] opAddiu   = 6'b001001;
	localparam logic [5:0] opSlti    = 6'b001010;
	localparam logic [5:0] opSltiu   = 6'b001011;
	localparam logic [5:0] opAndi    = 6'b001100;
	localparam logic [5:0] opOri     = 6'b001101;
	localparam logic [5:0] opXori    = 6'b001110;
	localparam logic [5:0] opLui     = 6'b001111;
	localparam logic [5:0] opLb      = 6'b100000;
	localparam logic [5:0] opLh      = 6'b100001;
	localparam logic [5:0] opLw      = 6'b100011;
	localparam logic [5:0] opLbu     = 6'b100100;
	localparam logic [5:0] opLhu     = 6'b100101;
	localparam logic [5:0] opSb      = 6'b101000;
	localparam logic [5:0] opSh      = 6'b101001;
	localparam logic [5:0] opSw      = 6'b101011;

	localparam logic [5:0] fnSll  = 6'b000000;
	localparam logic [5:0] fnSrl  = 6'b000010;
	localparam logic [5:0] fnSra  = 6'b000011;
	localparam logic [5:0] fnSllv = 6'b000100;
	localparam logic [5:0] fnSrlv = 6'b000110;
	localparam logic [5:0] fnSrav = 6'b000111;
	localparam logic [5:0] fnJr   = 6'b001000;
	localparam logic [5:0] fnJalr = 6'b001001;
	localparam logic [5:0] fnAdd  = 6'b100000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSub  = 6'b100010;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnXor  = 6'b100110;
	localparam logic [5:0] fnNor  = 6'b100111;
	localparam logic [5:0] fnSlt  = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	localparam regAddrT linkReg = 5'd31;
	localparam wordT    pcStep  = 32'd4;

endpackage

//--- design/instDecoder.sv
`timescale 1ns/100ps

module instDecoder import mipsPkg::*; (
	input  wordT instr,
	output ctrlT ctrl
);

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddrT rt;
	regAddrT rd;
	logic known;

	assign opcode = instr[31:26];
	assign funct  = instr[5:0];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	always_comb begin
		ctrl = '0;
		known = 1'b1;
		case (opcode)
			opSpecial: begin
				case (funct)
					fnSll, fnSrl, fnSra, fnSllv, fnSrlv, fnSrav: begin
						ctrl.isShift = 1'b1;
						ctrl.shiftOp = funct[1] ? (funct[0] ? shSra : shSrl) : shSll;
					end
					fnJr: begin
						ctrl.isJump = 1'b1;
						ctrl.isRegJump = 1'b1;
					end
					fnJalr: begin
						ctrl.isJump = 1'b1;
						ctrl.isRegJump = 1'b1;
						ctrl.isLink = 1'b1;
						ctrl.aSrc = srcLink;
						ctrl.bSrc = srcStep;
					end
					fnAdd, fnAddu: ctrl.aluOp = aluAdd;
					fnSub, fnSubu: ctrl.aluOp = aluSub;
					fnAnd: ctrl.aluOp = aluAnd;
					fnOr: ctrl.aluOp = aluOr;
					fnXor: ctrl.aluOp = aluXor;
					fnNor: ctrl.aluOp = aluNor;
					fnSlt: ctrl.aluOp = aluSlt;
					fnSltu: ctrl.aluOp = aluSltu;
					default: known = 1'b0;
				endcase
				// every R-type writes rd, except jr
				ctrl.regWriteEnable = (funct != fnJr);
				ctrl.writeReg = (funct != fnJr) ? rd : '0;
			end
			opRegimm: begin
				// only bltz and bgez, rt selects which
				known = (rt[4:1] == 4'b0000);
				ctrl.isBranch = 1'b1;
				ctrl.branchKind = rt[0] ? brGez : brLtz;
			end
			opJ: ctrl.isJump = 1'b1;
			opJal: begin
				ctrl.isJump = 1'b1;
				ctrl.isLink = 1'b1;
				ctrl.aSrc = srcLink;
				ctrl.bSrc = srcStep;
				ctrl.regWriteEnable = 1'b1;
				ctrl.writeReg = linkReg;
			end
			opBeq, opBne, opBlez, opBgtz: begin
				ctrl.isBranch = 1'b1;
				case (opcode[1:0])
					2'b00: ctrl.branchKind = brEq;
					2'b01: ctrl.branchKind = brNe;
					2'b10: ctrl.branchKind = brLez;
					default: ctrl.branchKind = brGtz;
				endcase
			end
			opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: begin
				ctrl.bSrc = srcImm;
				ctrl.regWriteEnable = 1'b1;
				ctrl.writeReg = rt;
				case (opcode)
					opSlti: ctrl.aluOp = aluSlt;
					opSltiu: ctrl.aluOp = aluSltu;
					opAndi: ctrl.aluOp = aluAnd;
					opOri: ctrl.aluOp = aluOr;
					opXori: ctrl.aluOp = aluXor;
					default: ctrl.aluOp = aluAdd;
				endcase
				// logical immediates are zero extended
				if (opcode[2]) begin
					ctrl.immKind = immZero;
				end
				if (opcode == opLui) begin
					ctrl.immKind = immUpper;
					ctrl.aSrc = srcZero;
				end
			end
			opLb, opLh, opLw, opLbu, opLhu: begin
				ctrl.isLoad = 1'b1;
				ctrl.bSrc = srcImm;
				ctrl.regWriteEnable = 1'b1;
				ctrl.writeReg = rt;
				ctrl.loadUnsigned = opcode[2];
				ctrl.accessSize = opcode[1] ? sizeWord : (opcode[0] ? sizeHalf : sizeByte);
			end
			opSb, opSh, opSw: begin
				ctrl.isStore = 1'b1;
				ctrl.bSrc = srcImm;
				ctrl.accessSize = opcode[1] ? sizeWord : (opcode[0] ? sizeHalf : sizeByte);
			end
			default: known = 1'b0;
		endcase

		// all-zero word and anything unrecognized become a nop
		if (!known || instr == '0) begin
			ctrl = '0;
			ctrl.isNop = 1'b1;
		end
	end

endmodule

//--- design/executeUnit.sv
`timescale 1ns/100ps

module executeUnit import mipsPkg::*; (
	input  ctrlT ctrl,
	input  wordT instr,
	input  wordT pc,
	input  wordT rsData,
	input  wordT rtData,
	output wordT aluResult,
	output wordT shiftResult,
	output logic branchTaken,
	output wordT nextPc
);

	wordT immExt;
	wordT opA;
	wordT opB;
	wordT seqPc;
	wordT branchTarget;
	wordT jumpTarget;
	logic [4:0] shamt;
	logic condMet;

	assign seqPc = pc + pcStep;

	always_comb begin
		case (ctrl.immKind)
			immZero: immExt = {16'h0000, instr[15:0]};
			immUpper: immExt = {instr[15:0], 16'h0000};
			default: immExt = {{16{instr[15]}}, instr[15:0]};
		endcase
	end

	// links compute pc + 8 as (pc + 4) + 4
	always_comb begin
		case (ctrl.aSrc)
			srcLink: opA = seqPc;
			srcZero: opA = '0;
			default: opA = rsData;
		endcase
		case (ctrl.bSrc)
			srcImm: opB = immExt;
			srcStep: opB = pcStep;
			default: opB = rtData;
		endcase
	end

	always_comb begin
		case (ctrl.aluOp)
			aluSub: aluResult = opA - opB;
			aluAnd: aluResult = opA & opB;
			aluOr: aluResult = opA | opB;
			aluXor: aluResult = opA ^ opB;
			aluNor: aluResult = ~(opA | opB);
			aluSlt: aluResult = {31'b0, $signed(opA) < $signed(opB)};
			aluSltu: aluResult = {31'b0, opA < opB};
			default: aluResult = opA + opB;
		endcase
	end

	// funct[2] marks the variable shifts
	assign shamt = instr[2] ? rsData[4:0] : instr[10:6];

	always_comb begin
		case (ctrl.shiftOp)
			shSrl: shiftResult = rtData >> shamt;
			shSra: shiftResult = $signed(rtData) >>> shamt;
			default: shiftResult = rtData << shamt;
		endcase
	end

	always_comb begin
		case (ctrl.branchKind)
			brEq: condMet = (rsData == rtData);
			brNe: condMet = (rsData != rtData);
			brLez: condMet = rsData[31] | (rsData == '0);
			brGtz: condMet = ~rsData[31] & (rsData != '0);
			brLtz: condMet = rsData[31];
			default: condMet = ~rsData[31];
		endcase
	end

	assign branchTaken  = ctrl.isBranch & condMet;
	assign branchTarget = seqPc + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget   = {seqPc[31:28], instr[25:0], 2'b00};

	assign nextPc = ctrl.isRegJump ? rsData
	              : ctrl.isJump    ? jumpTarget
	              : branchTaken    ? branchTarget
	              :                  seqPc;

endmodule

//--- design/regFile.sv
`timescale 1ns/100ps

module regFile import mipsPkg::*; (
	input  logic    clk,
	input  regAddrT raddr1,
	input  regAddrT raddr2,
	output wordT    rdata1,
	output wordT    rdata2,
	input  logic    wen,
	input  regAddrT waddr,
	input  wordT    wdata
);

	wordT regs [32];

	always_ff @(posedge clk) begin
		if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	// $0 is never written, so force zero on read
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/memAligner.sv
`timescale 1ns/100ps

module memAligner import mipsPkg::*; (
	input  ctrlT       ctrl,
	input  wordT       addr,
	input  wordT       storeSrc,
	input  wordT       loadWord,
	output wordT       storeData,
	output logic [3:0] storeStrb,
	output wordT       loadValue
);

	logic [1:0] offset;
	logic [7:0] loadByte;
	logic [15:0] loadHalf;

	assign offset = addr[1:0];

	// store lanes, data replicated so any offset lines up
	always_comb begin
		case (ctrl.accessSize)
			sizeByte: begin
				storeData = {4{storeSrc[7:0]}};
				storeStrb = 4'b0001 << offset;
			end
			sizeHalf: begin
				storeData = {2{storeSrc[15:0]}};
				storeStrb = offset[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				storeData = storeSrc;
				storeStrb = 4'b1111;
			end
		endcase
	end

	assign loadByte = loadWord[{offset, 3'b000} +: 8];
	assign loadHalf = offset[1] ? loadWord[31:16] : loadWord[15:0];

	always_comb begin
		case (ctrl.accessSize)
			sizeByte: begin
				if (ctrl.loadUnsigned) begin
					loadValue = {24'h000000, loadByte};
				end else begin
					loadValue = {{24{loadByte[7]}}, loadByte};
				end
			end
			sizeHalf: begin
				if (ctrl.loadUnsigned) begin
					loadValue = {16'h0000, loadHalf};
				end else begin
					loadValue = {{16{loadHalf[15]}}, loadHalf};
				end
			end
			default: loadValue = loadWord;
		endcase
	end

endmodule

//--- design/cpuSequencer.sv
`timescale 1ns/100ps

module cpuSequencer import mipsPkg::*; #(
	parameter wordT resetPc = '0
) (
	input  logic       clk,
	input  logic       rst,
	input  ctrlT       ctrl,
	input  wordT       nextPc,
	input  wordT       aluResult,
	input  wordT       shiftResult,
	input  wordT       loadValue,
	input  wordT       storeData,
	input  logic [3:0] storeStrb,
	input  wordT       instrIn,
	input  logic       instValid,
	input  logic       instReqReady,
	input  logic       memReqReady,
	input  logic       readValid,
	input  wordT       readDataIn,
	output wordT       pc,
	output wordT       instr,
	output wordT       loadWord,
	output logic       instReqValid,
	output logic       instReady,
	output memReqT     memReq,
	output logic       memReqValid,
	output logic       readReady,
	output logic       rfWen,
	output regAddrT    rfWaddr,
	output wordT       rfWdata,
	output retireT     retire,
	output logic       retireValid
);

	typedef enum logic [7:0] {
		stFetch     = 8'b00000001,
		stInstWait  = 8'b00000010,
		stDecode    = 8'b00000100,
		stExecute   = 8'b00001000,
		stStore     = 8'b00010000,
		stLoad      = 8'b00100000,
		stReadWait  = 8'b01000000,
		stWriteback = 8'b10000000
	} stateT;

	stateT state;
	stateT stateNext;
	wordT pcReg;
	wordT instrReg;
	wordT readReg;
	logic execRetire;

	// branches, j and jr finish in execute
	assign execRetire = ctrl.isBranch | (ctrl.isJump & ~ctrl.isLink);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stFetch;
		end else begin
			state <= stateNext;
		end
	end

	always_comb begin
		stateNext = state;
		case (state)
			stFetch: if (instReqReady) stateNext = stInstWait;
			stInstWait: if (instValid) stateNext = stDecode;
			stDecode: stateNext = ctrl.isNop ? stFetch : stExecute;
			stExecute: begin
				if (execRetire) begin
					stateNext = stFetch;
				end else if (ctrl.isStore) begin
					stateNext = stStore;
				end else if (ctrl.isLoad) begin
					stateNext = stLoad;
				end else begin
					stateNext = stWriteback;
				end
			end
			stStore: if (memReqReady) stateNext = stFetch;
			stLoad: if (memReqReady) stateNext = stReadWait;
			stReadWait: if (readValid) stateNext = stWriteback;
			stWriteback: stateNext = stFetch;
			default: stateNext = stFetch;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pcReg <= resetPc;
		end else if (retireValid) begin
			pcReg <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (state == stInstWait && instValid) begin
			instrReg <= instrIn;
		end
	end

	always_ff @(posedge clk) begin
		if (state == stReadWait && readValid) begin
			readReg <= readDataIn;
		end
	end

	assign pc       = pcReg;
	assign instr    = instrReg;
	assign loadWord = readReg;

	// first request goes out as soon as reset drops
	assign instReqValid = (state == stFetch) && !rst;
	assign instReady    = (state == stInstWait);
	assign memReqValid  = (state == stStore) || (state == stLoad);
	assign readReady    = (state == stReadWait);

	assign memReq = '{
		addr: {aluResult[31:2], 2'b00},
		wdata: storeData,
		strb: ctrl.isStore ? storeStrb : 4'b0000,
		write: ctrl.isStore
	};

	assign rfWen   = (state == stWriteback) && ctrl.regWriteEnable;
	assign rfWaddr = ctrl.writeReg;
	// link value comes through the ALU as pc + 8
	assign rfWdata = ctrl.isLoad  ? loadValue
	               : ctrl.isShift ? shiftResult
	               :                aluResult;

	assign retireValid = (state == stDecode && ctrl.isNop)
	                  || (state == stExecute && execRetire)
	                  || (state == stStore && memReqReady)
	                  || (state == stWriteback);

	assign retire = '{
		wen: rfWen,
		waddr: rfWen ? rfWaddr : '0,
		wdata: rfWen ? rfWdata : '0,
		pc: pcReg
	};

endmodule

//--- design/multiCycleCpu.sv
`timescale 1ns/100ps

module multiCycleCpu import mipsPkg::*; #(
	parameter wordT resetPc = '0
) (
	input  logic   clk,
	input  logic   rst,

	// fetch request
	output wordT   pc,
	output logic   instReqValid,
	input  logic   instReqReady,

	// instruction response
	input  wordT   instruction,
	input  logic   instValid,
	output logic   instReady,

	// memory request
	output memReqT memReq,
	output logic   memReqValid,
	input  logic   memReqReady,

	// read response
	input  wordT   readData,
	input  logic   readValid,
	output logic   readReady,

	output retireT retire,
	output logic   retireValid
);

	ctrlT ctrl;
	wordT instr;
	wordT rsData;
	wordT rtData;
	wordT aluResult;
	wordT shiftResult;
	wordT nextPc;
	wordT loadWord;
	wordT loadValue;
	wordT storeData;
	logic [3:0] storeStrb;
	logic rfWen;
	regAddrT rfWaddr;
	wordT rfWdata;

	cpuSequencer #(
		.resetPc(resetPc)
	) seq0 (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.nextPc(nextPc),
		.aluResult(aluResult),
		.shiftResult(shiftResult),
		.loadValue(loadValue),
		.storeData(storeData),
		.storeStrb(storeStrb),
		.instrIn(instruction),
		.instValid(instValid),
		.instReqReady(instReqReady),
		.memReqReady(memReqReady),
		.readValid(readValid),
		.readDataIn(readData),
		.pc(pc),
		.instr(instr),
		.loadWord(loadWord),
		.instReqValid(instReqValid),
		.instReady(instReady),
		.memReq(memReq),
		.memReqValid(memReqValid),
		.readReady(readReady),
		.rfWen(rfWen),
		.rfWaddr(rfWaddr),
		.rfWdata(rfWdata),
		.retire(retire),
		.retireValid(retireValid)
	);

	instDecoder decoder0 (
		.instr(instr),
		.ctrl(ctrl)
	);

	// rs and rt fields of the held instruction
	regFile regs0 (
		.clk(clk),
		.raddr1(instr[25:21]),
		.raddr2(instr[20:16]),
		.rdata1(rsData),
		.rdata2(rtData),
		.wen(rfWen),
		.waddr(rfWaddr),
		.wdata(rfWdata)
	);

	// branch decision is folded into nextPc
	executeUnit exec0 (
		.ctrl(ctrl),
		.instr(instr),
		.pc(pc),
		.rsData(rsData),
		.rtData(rtData),
		.aluResult(aluResult),
		.shiftResult(shiftResult),
		.branchTaken(),
		.nextPc(nextPc)
	);

	memAligner aligner0 (
		.ctrl(ctrl),
		.addr(aluResult),
		.storeSrc(rtData),
		.loadWord(loadWord),
		.storeData(storeData),
		.storeStrb(storeStrb),
		.loadValue(loadValue)
	);

endmodule

//--- bench/busHandshake_properties.sv
`timescale 1ns/100ps

module busHandshakeProperties import mipsPkg::*; (
	input logic   clk,
	input logic   rst,
	input wordT   pc,
	input logic   instReqValid,
	input logic   instReqReady,
	input logic   instReady,
	input memReqT memReq,
	input logic   memReqValid,
	input logic   memReqReady,
	input logic   readReady,
	input logic   retireValid
);

	pcHeld: assert property (@(posedge clk) disable iff (rst)
		instReqValid && !instReqReady |=> $stable(pc))
		else $error("fetch address changed while the request was stalled");

	memReqHeld: assert property (@(posedge clk) disable iff (rst)
		memReqValid && !memReqReady |=> $stable(memReq))
		else $error("memory request changed while stalled");

	// first edge of reset may still see the power-up state
	quietInReset: assert property (@(posedge clk)
		rst && $past(rst) |-> !(instReqValid || instReady || memReqValid || readReady
			|| retireValid))
		else $error("bus valid or ready high during reset");

	retireStrobe: assert property (@(posedge clk) disable iff (rst)
		retireValid |=> !retireValid)
		else $error("retire strobe lasted two cycles");

endmodule

bind multiCycleCpu busHandshakeProperties props0 (
	.clk(clk),
	.rst(rst),
	.pc(pc),
	.instReqValid(instReqValid),
	.instReqReady(instReqReady),
	.instReady(instReady),
	.memReq(memReq),
	.memReqValid(memReqValid),
	.memReqReady(memReqReady),
	.readReady(readReady),
	.retireValid(retireValid)
);

//--- bench/multiCycleCpuTb.sv
`timescale 1ns/100ps

module multiCycleCpuTb import mipsPkg::*; ();

	typedef logic [8*24-1:0] nameT;

	localparam int maxCycles = 20000;

	logic clk;
	logic rst;
	wordT pc;
	logic instReqValid;
	logic instReqReady;
	wordT instruction;
	logic instValid;
	logic instReady;
	memReqT memReq;
	logic memReqValid;
	logic memReqReady;
	wordT readData;
	logic readValid;
	logic readReady;
	retireT retire;
	logic retireValid;

	wordT instMem [256];
	wordT dataMem [256];

	retireT expRetire [$];
	nameT retireName [$];
	wordT memAddr [$];
	wordT memExp [$];
	nameT memName [$];

	int retIdx;
	int errorCount;
	int timeoutCount;
	logic [31:0] lcgState;

	// memory model state
	logic [1:0] fetchWait;
	logic [1:0] instWait;
	logic instPending;
	wordT instAddr;
	logic [1:0] reqWait;
	logic [1:0] readWait;
	logic readPending;
	wordT readAddr;

	multiCycleCpu #(
		.resetPc(32'h0000_0000)
	) dut0 (
		.clk(clk),
		.rst(rst),
		.pc(pc),
		.instReqValid(instReqValid),
		.instReqReady(instReqReady),
		.instruction(instruction),
		.instValid(instValid),
		.instReady(instReady),
		.memReq(memReq),
		.memReqValid(memReqValid),
		.memReqReady(memReqReady),
		.readData(readData),
		.readValid(readValid),
		.readReady(readReady),
		.retire(retire),
		.retireValid(retireValid)
	);

	always #10 clk = ~clk;

	// back-pressure delay of 0 to 3 cycles
	function automatic logic [1:0] randDelay();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[17:16];
	endfunction

	function automatic wordT mergeBytes(wordT oldWord, wordT newWord, logic [3:0] strb);
		wordT merged;
		merged = oldWord;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) begin
				merged[8*i +: 8] = newWord[8*i +: 8];
			end
		end
		return merged;
	endfunction

	task automatic compareRetire(nameT name, retireT expected, retireT actual);
		if (expected !== actual) begin
			$display("[FAIL] %0s expected pc %h w %b r%0d=%h actual pc %h w %b r%0d=%h",
				name, expected.pc, expected.wen, expected.waddr, expected.wdata,
				actual.pc, actual.wen, actual.waddr, actual.wdata);
			errorCount++;
		end
	endtask

	task automatic compareWord(nameT name, wordT expected, wordT actual);
		if (expected !== actual) begin
			$display("[FAIL] %0s expected %h actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic loadTests();
		int fd;
		int code;
		logic [7:0] tag;
		nameT name;
		logic [8*128-1:0] rest;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		logic [31:0] f5;
		retireT rec;
		fd = $fopen("bench/cpuTests.txt", "r");
		if (fd == 0) begin
			$display("could not open the test file bench/cpuTests.txt");
			errorCount++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1) begin
				break;
			end
			if (tag == "#") begin
				code = $fgets(rest, fd);
			end else if (tag == "P" || tag == "D" || tag == "M") begin
				code = $fscanf(fd, "%s %h %h", name, f1, f2);
				if (tag == "P") begin
					instMem[f1[9:2]] = f2;
				end else if (tag == "D") begin
					dataMem[f1[9:2]] = f2;
				end else begin
					memName.push_back(name);
					memAddr.push_back(f1);
					memExp.push_back(f2);
				end
			end else if (tag == "R") begin
				// retire line also places its instruction word
				code = $fscanf(fd, "%s %h %h %h %h %h", name, f1, f2, f3, f4, f5);
				instMem[f1[9:2]] = f2;
				rec = '{wen: f3[0], waddr: f4[4:0], wdata: f5, pc: f1};
				retireName.push_back(name);
				expRetire.push_back(rec);
			end else begin
				$display("unknown line tag in the test file");
				errorCount++;
			end
		end
		$fclose(fd);
	endtask

	// instruction and data memory models
	always @(posedge clk) begin
		if (rst) begin
			instReqReady <= 1'b0;
			instValid <= 1'b0;
			memReqReady <= 1'b0;
			readValid <= 1'b0;
			instPending <= 1'b0;
			readPending <= 1'b0;
			fetchWait <= randDelay();
			reqWait <= randDelay();
		end else begin
			if (instReqValid && instReqReady) begin
				instReqReady <= 1'b0;
				fetchWait <= randDelay();
				instPending <= 1'b1;
				instAddr <= pc;
				instWait <= randDelay();
			end else if (instReqValid) begin
				if (fetchWait == 2'd0) begin
					instReqReady <= 1'b1;
				end else begin
					fetchWait <= fetchWait - 2'd1;
				end
			end

			if (instValid && instReady) begin
				instValid <= 1'b0;
			end else if (instPending) begin
				if (instWait == 2'd0) begin
					instruction <= instMem[instAddr[9:2]];
					instValid <= 1'b1;
					instPending <= 1'b0;
				end else begin
					instWait <= instWait - 2'd1;
				end
			end

			if (memReqValid && memReqReady) begin
				memReqReady <= 1'b0;
				reqWait <= randDelay();
				if (memReq.write) begin
					dataMem[memReq.addr[9:2]] <= mergeBytes(dataMem[memReq.addr[9:2]],
						memReq.wdata, memReq.strb);
				end else begin
					readPending <= 1'b1;
					readAddr <= memReq.addr;
					readWait <= randDelay();
				end
			end else if (memReqValid) begin
				if (reqWait == 2'd0) begin
					memReqReady <= 1'b1;
				end else begin
					reqWait <= reqWait - 2'd1;
				end
			end

			if (readValid && readReady) begin
				readValid <= 1'b0;
			end else if (readPending) begin
				if (readWait == 2'd0) begin
					readData <= dataMem[readAddr[9:2]];
					readValid <= 1'b1;
					readPending <= 1'b0;
				end else begin
					readWait <= readWait - 2'd1;
				end
			end
		end
	end

	// extra retires of the halt loop are not checked
	always @(posedge clk) begin
		if (!rst && retireValid && retIdx < expRetire.size()) begin
			compareRetire(retireName[retIdx], expRetire[retIdx], retire);
			retIdx <= retIdx + 1;
		end
	end

	initial begin
		int cycles;
		clk = 1'b0;
		rst = 1'b1;
		instReqReady = 1'b0;
		instruction = '0;
		instValid = 1'b0;
		memReqReady = 1'b0;
		readData = '0;
		readValid = 1'b0;
		retIdx = 0;
		errorCount = 0;
		timeoutCount = 0;
		lcgState = 32'h212;
		for (int i = 0; i < 256; i++) begin
			// unknown opcode that decodes as a nop
			instMem[i] = 32'hfc00_0000 | (i << 2);
			dataMem[i] = 32'hdead_0000 | (i << 2);
		end
		loadTests();

		repeat (4) @(posedge clk);
		rst <= 1'b0;

		cycles = 0;
		while (retIdx < expRetire.size() && cycles < maxCycles) begin
			@(posedge clk);
			cycles++;
		end
		if (retIdx < expRetire.size()) begin
			$display("timeout: only %0d of %0d instructions retired", retIdx, expRetire.size());
			timeoutCount++;
		end
		// lets the last store land in memory
		@(posedge clk);

		for (int i = 0; i < memExp.size(); i++) begin
			compareWord(memName[i], memExp[i], dataMem[memAddr[i][9:2]]);
		end

		$display("mismatches %0d, timeouts %0d", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- bench/cpuTests.txt
# P name addr word | D name addr word | M name addr expected
# R name pc instruction wen waddr wdata  (retire order, also places the instruction)
D loadSrc 00000100 80ff7f01
D storeByte 00000104 11223344
D storeHalf 00000108 55667788
D storeWord 0000010c aabbccdd
D storeLink 00000110 00000000
P skipBne1 0000009c 24140bad
P skipBne2 000000a0 24140bad
P skipBlez 000000a8 24140bad
P skipBgez 000000b8 24140bad
P skipJal 000000c0 24140bad
R addiu 00000000 24017fff 1 01 00007fff
R lui 00000004 3c028000 1 02 80000000
R ori 00000008 34421234 1 02 80001234
R addu 0000000c 00221821 1 03 80009233
R subu 00000010 00222023 1 04 80006dcb
R and 00000014 00432824 1 05 80001230
R xor 00000018 00433026 1 06 00008007
R nor 0000001c 00203827 1 07 ffff8000
R slt 00000020 0041402a 1 08 00000001
R sltu 00000024 0041482b 1 09 00000000
R slti 00000028 28eaffff 1 0a 00000001
R sltiu 0000002c 2c2bffff 1 0b 00000001
R andi 00000030 30ecf0f0 1 0c 00008000
R xori 00000034 382dffff 1 0d 00008000
R sll 00000038 00027100 1 0e 00012340
R srl 0000003c 00027a02 1 0f 00800012
R sra 00000040 00028203 1 10 ff800012
R srav 00000044 00228807 1 11 ffffffff
R srlv 00000048 00229006 1 12 00000001
R sllv 0000004c 01619804 1 13 0000fffe
R writeR0 00000050 24000005 1 00 00000005
R readR0 00000054 0000a021 1 14 00000000
R nop 00000058 00000000 0 00 00000000
R loadBase 0000005c 24150100 1 15 00000100
R lbOff3 00000060 82b60003 1 16 ffffff80
R lbuOff2 00000064 92b70002 1 17 000000ff
R lbOff1 00000068 82b80001 1 18 0000007f
R lbuOff0 0000006c 92b90000 1 19 00000001
R lhOff2 00000070 86ba0002 1 1a ffff80ff
R lhuOff2 00000074 96bb0002 1 1b 000080ff
R lhOff0 00000078 86bc0000 1 1c 00007f01
R lw 0000007c 8ebd0000 1 1d 80ff7f01
R sbOff1 00000080 a2a60005 0 00 00000000
R sbOff3 00000084 a2a10007 0 00 00000000
R shOff2 00000088 a6a7000a 0 00 00000000
R sw 0000008c aea2000c 0 00 00000000
R lwAfterSb 00000090 8ebe0004 1 1e ff220744
R beqUntaken 00000094 10080003 0 00 00000000
R bneTaken 00000098 14080002 0 00 00000000
R blezTaken 000000a4 18e00001 0 00 00000000
R bgtzUntaken 000000ac 1ce00001 0 00 00000000
R bltzUntaken 000000b0 04200001 0 00 00000000
R bgezTaken 000000b4 04210001 0 00 00000000
R jal 000000bc 0c000034 1 1f 000000c4
R j 000000d0 08000038 0 00 00000000
R jalrTarget 000000e0 240500f0 1 05 000000f0
R jalr 000000e4 00a0c809 1 19 000000ec
R jr 000000f0 03e00008 0 00 00000000
R orR0 000000c4 0000c025 1 18 00000000
R swLink 000000c8 aeb90010 0 00 00000000
R halt 000000cc 08000033 0 00 00000000
M memLoadSrc 00000100 80ff7f01
M memByte 00000104 ff220744
M memHalf 00000108 80007788
M memWord 0000010c 80001234
M memLink 00000110 000000ec

//--- multiCycleCpu.f
design/mipsPkg.sv
design/instDecoder.sv
design/executeUnit.sv
design/regFile.sv
design/memAligner.sv
design/cpuSequencer.sv
design/multiCycleCpu.sv
bench/busHandshake_properties.sv
bench/multiCycleCpuTb.sv

//--- runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f multiCycleCpu.f --top-module multiCycleCpuTb -o simv
output=$(./obj_dir/simv || true)
echo "$output"
echo "$output" | grep -q "SIMULATION PASSED"
